// File: positDotUnit.f
source/positFormatPkg.sv
source/dotStreamPkg.sv
source/pipeStage.sv
source/positDecode.sv
source/positProductAlign.sv
source/quireAccumulate.sv
source/positEncode.sv
source/positDotUnit.sv
verification/positDotUnitTb.sv

// File: Bender.yml
package:
  name: positDotUnit

sources:
  - files:
      - source/positFormatPkg.sv
      - source/dotStreamPkg.sv
      - source/pipeStage.sv
      - source/positDecode.sv
      - source/positProductAlign.sv
      - source/quireAccumulate.sv
      - source/positEncode.sv
      - source/positDotUnit.sv
  - target: test
    files:
      - verification/positDotUnitTb.sv

// File: verification/positDotUnitTb.sv
// posit dot unit testbench
`timescale 1ns/100ps

module positDotUnitTb;

  import positFormatPkg::*;
  import dotStreamPkg::*;

  localparam int NumPairs = 25;
  localparam int NumVectors = 15;
  localparam int ReadyTimeout = 200;
  localparam int ResultTimeout = 400;
  localparam int DrainCycles = 40;

  // ====================
  // stimulus table
  // ====================
  // one row per pair: {a, b, last}
  localparam logic [32:0] PairTable [NumPairs] = '{
    // exact single products
    {16'h4000, 16'h4000, 1'b1},
    {16'h5000, 16'h3000, 1'b1},
    {16'hC000, 16'h5000, 1'b1},
    {16'h4800, 16'h4800, 1'b1},
    // 1 + 1 + 2
    {16'h4000, 16'h4000, 1'b0},
    {16'h5000, 16'h3000, 1'b0},
    {16'h4000, 16'h5000, 1'b1},
    // terms cancel
    {16'h4000, 16'h4000, 1'b0},
    {16'hC000, 16'h4000, 1'b1},
    // (1+2^-12)^2 - (1+2^-11) leaves exactly 2^-24
    {16'h4001, 16'h4001, 1'b0},
    {16'h4002, 16'hC000, 1'b1},
    // NaR in the middle poisons the whole vector
    {16'h4000, 16'h5000, 1'b0},
    {16'h8000, 16'h4000, 1'b0},
    {16'h4000, 16'h4000, 1'b1},
    // next vector must come out clean
    {16'h4000, 16'h4000, 1'b1},
    // zero operands only
    {16'h0000, 16'h0000, 1'b0},
    {16'h0000, 16'h4000, 1'b1},
    // 2^28 + 2^28 is past maxpos
    {16'h7FFF, 16'h4000, 1'b0},
    {16'h7FFF, 16'h4000, 1'b1},
    // -2^30 clamps to negative maxpos
    {16'h8001, 16'h6000, 1'b1},
    // 2^-56 clamps up to minpos
    {16'h0001, 16'h0001, 1'b1},
    // 1 + 2^-13 is a tie, even side is down
    {16'h4000, 16'h4000, 1'b0},
    {16'h00C0, 16'h4000, 1'b1},
    // 1 + 3*2^-13 is a tie, even side is up
    {16'h4000, 16'h4000, 1'b0},
    {16'h0140, 16'h4000, 1'b1}
  };

  // expected posit per vector, in table order
  localparam logic [15:0] ExpectedTable [NumVectors] = '{
    16'h4000, 16'h4000, 16'hB000, 16'h5200, 16'h6000,
    16'h0000, 16'h0004, 16'h8000, 16'h4000, 16'h0000,
    16'h7FFF, 16'h8001, 16'h0001, 16'h4000, 16'h4002
  };

  logic clk;
  logic reset;
  logic inValid;
  logic inReady;
  operandPairT inPair;
  logic outValid;
  logic outReady;
  positT outResult;

  integer seed;
  int errorCount;
  int checkCount;
  int resultCount;

  positDotUnit #(
    .guardBits(8)
  ) dut (
    .clk(clk),
    .reset(reset),
    .inValid(inValid),
    .inReady(inReady),
    .inPair(inPair),
    .outValid(outValid),
    .outReady(outReady),
    .outResult(outResult)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // random back-pressure, ready about three cycles in four
  always @(posedge clk) begin
    outReady <= ($random(seed) & 3) != 0;
  end

  task automatic checkValue(input string name, input logic [31:0] actual,
                            input logic [31:0] expected);
    checkCount++;
    if (actual !== expected) begin
      errorCount++;
      $display("Error: %s is 0x%h, expected 0x%h", name, actual, expected);
    end
  endtask

  // ====================
  // stream processes
  // ====================
  task automatic feedPairs();
    int waitCount;
    for (int i = 0; i < NumPairs; i++) begin
      inValid <= 1'b1;
      inPair <= PairTable[i];
      waitCount = 0;
      @(posedge clk);
      // pair is taken on the first edge that sees ready high
      while (!inReady && waitCount < ReadyTimeout) begin
        @(posedge clk);
        waitCount++;
      end
      if (!inReady) begin
        errorCount++;
        $display("Timeout: the unit never accepted operand pair %0d", i);
        inValid <= 1'b0;
        return;
      end
    end
    inValid <= 1'b0;
  endtask

  task automatic collectResults();
    int waitCount;
    logic gotResult;
    for (int v = 0; v < NumVectors; v++) begin
      waitCount = 0;
      gotResult = 1'b0;
      while (!gotResult && waitCount < ResultTimeout) begin
        @(posedge clk);
        waitCount++;
        if (outValid && outReady) begin
          gotResult = 1'b1;
          resultCount++;
          checkValue("outResult", 32'(outResult), 32'(ExpectedTable[v]));
        end
      end
      if (!gotResult) begin
        errorCount++;
        $display("Timeout: no result arrived for vector %0d", v);
        return;
      end
    end
  endtask

  // nothing may come out once every vector is accounted for
  task automatic checkNoExtra();
    for (int i = 0; i < DrainCycles; i++) begin
      @(posedge clk);
      if (outValid && outReady) begin
        resultCount++;
        errorCount++;
        $display("Unexpected extra result 0x%h after the last vector", outResult);
      end
    end
  endtask

  initial begin
    seed = 37;
    errorCount = 0;
    checkCount = 0;
    resultCount = 0;
    reset = 1'b1;
    inValid = 1'b0;
    inPair = '0;
    outReady = 1'b0;
    repeat (16) @(posedge clk);
    reset <= 1'b0;
    @(posedge clk);
    fork
      feedPairs();
      collectResults();
    join
    checkNoExtra();
    checkValue("resultCount", 32'(resultCount), 32'(NumVectors));
    $display("checks: %0d, errors: %0d", checkCount, errorCount);
    if (errorCount == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

// File: source/positDotUnit.sv
// posit16 fused dot product unit
`timescale 1ns/100ps

module positDotUnit #(
  parameter int guardBits = 8
) (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      inValid,
  output logic                      inReady,
  input  dotStreamPkg::operandPairT inPair,
  output logic                      outValid,
  input  logic                      outReady,
  output positFormatPkg::positT     outResult
);

  import dotStreamPkg::*;

  // stage to stage streams
  decodedPairT decodedData;
  logic decodedValid;
  logic decodedReady;
  alignedTermT termData;
  logic termValid;
  logic termReady;
  logic [QuireFracBits+QuireIntBits+guardBits:0] quireData;
  logic quireValid;
  logic quireReady;

  positDecode decode (
    .clk(clk),
    .reset(reset),
    .inValid(inValid),
    .inReady(inReady),
    .inPair(inPair),
    .outValid(decodedValid),
    .outReady(decodedReady),
    .outPair(decodedData)
  );

  positProductAlign align (
    .clk(clk),
    .reset(reset),
    .inValid(decodedValid),
    .inReady(decodedReady),
    .inPair(decodedData),
    .outValid(termValid),
    .outReady(termReady),
    .outTerm(termData)
  );

  quireAccumulate #(
    .guardBits(guardBits)
  ) accumulate (
    .clk(clk),
    .reset(reset),
    .inValid(termValid),
    .inReady(termReady),
    .inTerm(termData),
    .outValid(quireValid),
    .outReady(quireReady),
    .outQuire(quireData)
  );

  positEncode #(
    .guardBits(guardBits)
  ) encode (
    .clk(clk),
    .reset(reset),
    .inValid(quireValid),
    .inReady(quireReady),
    .inQuire(quireData),
    .outValid(outValid),
    .outReady(outReady),
    .outResult(outResult)
  );

endmodule

// File: source/positEncode.sv
// quire to posit16 encoder
`timescale 1ns/100ps

module positEncode #(
  parameter int guardBits = 8
) (
  input  logic clk,
  input  logic reset,
  input  logic inValid,
  output logic inReady,
  input  logic [dotStreamPkg::QuireFracBits+dotStreamPkg::QuireIntBits+guardBits:0] inQuire,
  output logic outValid,
  input  logic outReady,
  output positFormatPkg::positT outResult
);

  import positFormatPkg::*;
  import dotStreamPkg::*;

  localparam int QuireWidth = QuireFracBits + QuireIntBits + guardBits;
  // largest regime is PositWidth-2, so +/-28 for es = 1
  localparam int MaxScale = (PositWidth - 2) << ExpSize;
  // regime pattern, terminator, exponent and the whole fraction
  localparam int BaseWidth = PositWidth + ExpSize + QuireWidth - 1;

  typedef struct packed {
    logic signed [QuireWidth-1:0] value;
    logic nar;
  } quireT;

  quireT quireIn;
  logic negative;
  logic [QuireWidth-1:0] magnitude;
  logic [QuireWidth-1:0] normalized;
  int leadPos;
  int scale;
  int regime;
  int shiftAmount;
  logic regimeNeg;
  logic [ExpSize-1:0] expBits;
  logic [BaseWidth-1:0] baseString;
  logic [BaseWidth-1:0] shiftedString;
  logic [PositWidth-2:0] body;
  logic [PositWidth-2:0] rounded;
  logic guardBit;
  logic stickyBit;
  logic roundUp;
  positT encoded;

  assign quireIn = inQuire;
  assign negative = quireIn.value[QuireWidth-1];
  assign magnitude = negative ? -quireIn.value : quireIn.value;

  // ====================
  // normalize and round
  // ====================
  always_comb begin
    // leading one gives the scale relative to the binary point
    leadPos = 0;
    for (int i = 0; i < QuireWidth; i++) begin
      if (magnitude[i]) begin
        leadPos = i;
      end
    end
    scale = leadPos - QuireFracBits;
    normalized = magnitude << (QuireWidth - 1 - leadPos);
    regime = scale >>> ExpSize;
    expBits = scale[ExpSize-1:0];
    regimeNeg = (regime < 0);
    // fifteen regime bits, then trim the extra ones off the top
    baseString = {{(PositWidth-1){~regimeNeg}}, regimeNeg, expBits,
                  normalized[QuireWidth-2:0]};
    shiftAmount = regimeNeg ? PositWidth - 1 + regime : PositWidth - 2 - regime;
    shiftedString = baseString << shiftAmount;
    body = shiftedString[BaseWidth-1 -: PositWidth-1];
    guardBit = shiftedString[BaseWidth-PositWidth];
    stickyBit = |shiftedString[BaseWidth-PositWidth-1:0];
    // nearest even, a carry walks cleanly into exponent and regime
    roundUp = guardBit && (stickyBit || body[0]);
    rounded = body + (PositWidth-1)'(roundUp);
    // out of range saturates, never to zero or NaR
    if (scale > MaxScale) begin
      rounded = MaxPos[PositWidth-2:0];
    end else if (scale < -MaxScale) begin
      rounded = (PositWidth-1)'(1);
    end
    encoded = negative ? -{1'b0, rounded} : {1'b0, rounded};
    if (quireIn.nar) begin
      encoded = NarPattern;
    end else if (magnitude == '0) begin
      encoded = '0;
    end
  end

  pipeStage #(
    .payloadT(positT)
  ) encodeStage (
    .clk(clk),
    .reset(reset),
    .inValid(inValid),
    .inReady(inReady),
    .inData(encoded),
    .outValid(outValid),
    .outReady(outReady),
    .outData(outResult)
  );

endmodule

// File: source/quireAccumulate.sv
// quire accumulator
`timescale 1ns/100ps

module quireAccumulate #(
  parameter int guardBits = 8
) (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      inValid,
  output logic                      inReady,
  input  dotStreamPkg::alignedTermT inTerm,
  output logic                      outValid,
  input  logic                      outReady,
  output logic [dotStreamPkg::QuireFracBits+dotStreamPkg::QuireIntBits+guardBits:0] outQuire
);

  import dotStreamPkg::*;

  localparam int TermWidth = QuireFracBits + QuireIntBits;
  localparam int QuireWidth = TermWidth + guardBits;

  // completed vector total handed to the encoder
  typedef struct packed {
    logic signed [QuireWidth-1:0] value;
    logic nar;
  } quireT;

  logic signed [QuireWidth-1:0] runningSum;
  logic runningNar;
  logic signed [QuireWidth-1:0] extendedTerm;
  logic stageReady;
  logic accept;
  quireT total;
  quireT stageOut;

  // guard bits copy the term sign
  assign extendedTerm = {{guardBits{inTerm.product[TermWidth-1]}}, inTerm.product};
  assign total.value = runningSum + extendedTerm;
  assign total.nar = runningNar | inTerm.nar;

  // only a last term needs room in the output register
  assign inReady = inTerm.last ? stageReady : 1'b1;
  assign accept = inValid && inReady;

  always_ff @(posedge clk) begin
    if (reset) begin
      runningSum <= '0;
      runningNar <= 1'b0;
    end else if (accept) begin
      if (inTerm.last) begin
        // vector done, start the next one from zero
        runningSum <= '0;
        runningNar <= 1'b0;
      end else begin
        runningSum <= total.value;
        runningNar <= total.nar;
      end
    end
  end

  pipeStage #(
    .payloadT(quireT)
  ) totalStage (
    .clk(clk),
    .reset(reset),
    .inValid(inValid && inTerm.last),
    .inReady(stageReady),
    .inData(total),
    .outValid(outValid),
    .outReady(outReady),
    .outData(stageOut)
  );

  assign outQuire = stageOut;

endmodule

// File: source/positProductAlign.sv
// exact product and quire alignment
`timescale 1ns/100ps

module positProductAlign (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      inValid,
  output logic                      inReady,
  input  dotStreamPkg::decodedPairT inPair,
  output logic                      outValid,
  input  logic                      outReady,
  output dotStreamPkg::alignedTermT outTerm
);

  import positFormatPkg::*;
  import dotStreamPkg::*;

  // 1.x times 1.x, two integer bits then the fraction
  localparam int ProdWidth = 2 * SigWidth;
  localparam int ProdFracBits = ProdWidth - 2;
  localparam int TermWidth = QuireFracBits + QuireIntBits;
  // room below the quire lsb so the shift never goes right
  localparam int WideWidth = TermWidth + ProdFracBits;

  logic [ProdWidth-1:0] product;
  logic signed [ScaleWidth:0] scaleSum;
  logic [WideWidth-1:0] placed;
  logic [TermWidth-1:0] magnitude;
  logic negate;
  logic anyZero;
  logic anyNar;
  alignedTermT term;

  // full width product, nothing rounded away
  assign product = inPair.a.sig * inPair.b.sig;
  assign scaleSum = inPair.a.scale + inPair.b.scale;
  assign negate = inPair.a.sign ^ inPair.b.sign;
  assign anyZero = inPair.a.zero || inPair.b.zero;
  assign anyNar = inPair.a.nar || inPair.b.nar;

  // product lsb lands at bit scaleSum + 56 of the wide grid
  assign placed = WideWidth'(product) << (scaleSum + QuireFracBits);
  assign magnitude = placed[WideWidth-1 -: TermWidth];

  always_comb begin
    if (anyZero || anyNar) begin
      term.product = '0;
    end else if (negate) begin
      term.product = -magnitude;
    end else if (magnitude[TermWidth-1]) begin
      // maxpos squared is the one positive term that reaches the sign bit
      term.product = {1'b0, {(TermWidth-1){1'b1}}};
    end else begin
      term.product = magnitude;
    end
    term.nar = anyNar;
    term.last = inPair.last;
  end

  pipeStage #(
    .payloadT(alignedTermT)
  ) alignStage (
    .clk(clk),
    .reset(reset),
    .inValid(inValid),
    .inReady(inReady),
    .inData(term),
    .outValid(outValid),
    .outReady(outReady),
    .outData(outTerm)
  );

endmodule

// File: source/positDecode.sv
// posit operand decoder
`timescale 1ns/100ps

module positDecode (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      inValid,
  output logic                      inReady,
  input  dotStreamPkg::operandPairT inPair,
  output logic                      outValid,
  input  logic                      outReady,
  output dotStreamPkg::decodedPairT outPair
);

  import positFormatPkg::*;
  import dotStreamPkg::*;

  decodedPairT decoded;

  // split one posit into sign, scale, significand and flags
  function automatic decodedPositT decodePosit(input positT word);
    positT absWord;
    logic regimeBit;
    int runLength;
    int regime;
    logic [PositWidth-2:0] remainder;
    logic [ExpSize-1:0] expBits;
    decodedPositT result;
    // negative posits are decoded from their two's complement
    absWord = word[PositWidth-1] ? -word : word;
    regimeBit = absWord[PositWidth-2];
    // highest bit that breaks the run sets its length
    runLength = PositWidth - 1;
    for (int i = 0; i < PositWidth - 1; i++) begin
      if (absWord[i] != regimeBit) begin
        runLength = PositWidth - 2 - i;
      end
    end
    regime = regimeBit ? runLength - 1 : -runLength;
    // drop the run and its terminator, exponent is then on top
    remainder = absWord[PositWidth-2:0] << (runLength + 1);
    expBits = remainder[PositWidth-2 -: ExpSize];
    result.sign = word[PositWidth-1];
    result.zero = (word == '0);
    result.nar = (word == NarPattern);
    result.scale = ScaleWidth'((regime << ExpSize) + expBits);
    // hidden one in front, fraction left aligned
    result.sig = {1'b1, remainder[PositWidth-2-ExpSize -: SigWidth-1]};
    return result;
  endfunction

  assign decoded.a = decodePosit(inPair.a);
  assign decoded.b = decodePosit(inPair.b);
  assign decoded.last = inPair.last;

  pipeStage #(
    .payloadT(decodedPairT)
  ) decodeStage (
    .clk(clk),
    .reset(reset),
    .inValid(inValid),
    .inReady(inReady),
    .inData(decoded),
    .outValid(outValid),
    .outReady(outReady),
    .outData(outPair)
  );

endmodule

// File: source/pipeStage.sv
// valid/ready register slice
`timescale 1ns/100ps

module pipeStage #(
  parameter type payloadT = logic
) (
  input  logic    clk,
  input  logic    reset,
  input  logic    inValid,
  output logic    inReady,
  input  payloadT inData,
  output logic    outValid,
  input  logic    outReady,
  output payloadT outData
);

  logic full;

  // space when empty, or when the held item leaves this cycle
  assign inReady = !full || outReady;
  assign outValid = full;

  // occupancy follows the input whenever the slot can be rewritten
  always_ff @(posedge clk) begin
    if (reset) begin
      full <= 1'b0;
    end else if (inReady) begin
      full <= inValid;
    end
  end

  // payload register, loaded only on an accepted input
  always_ff @(posedge clk) begin
    if (inValid && inReady) begin
      outData <= inData;
    end
  end

endmodule

// File: source/dotStreamPkg.sv
// dot product stream payloads
package dotStreamPkg;

  import positFormatPkg::*;

  // quire fixed point, 2^-56 up to 2^56 before guard bits
  localparam int QuireFracBits = 56;
  localparam int QuireIntBits = 57;

  // raw operand pair as it enters the unit
  typedef struct packed {
    positT a;
    positT b;
    logic last;
  } operandPairT;

  // both operands split into fields
  typedef struct packed {
    decodedPositT a;
    decodedPositT b;
    logic last;
  } decodedPairT;

  // exact product already placed on the quire grid
  typedef struct packed {
    logic signed [QuireFracBits+QuireIntBits-1:0] product;
    logic nar;
    logic last;
  } alignedTermT;

endpackage

// File: source/positFormatPkg.sv
// posit16 format definitions
package positFormatPkg;

  // ====================
  // field sizes
  // ====================

  // bits per posit word
  localparam int PositWidth = 16;
  // exponent field bits (es)
  localparam int ExpSize = 1;
  // signed scale, regime * 2 + exponent, covers +/-28
  localparam int ScaleWidth = 6;
  // significand including the hidden one, left aligned
  localparam int SigWidth = 14;

  typedef logic [PositWidth-1:0] positT;

  // one operand after decoding
  typedef struct packed {
    logic sign;
    logic nar;
    logic zero;
    logic signed [ScaleWidth-1:0] scale;
    logic [SigWidth-1:0] sig;
  } decodedPositT;

  // ====================
  // special encodings
  // ====================
  localparam positT NarPattern = 16'h8000;
  localparam positT MaxPos = 16'h7FFF;

endpackage
